// File: flist.f
design/lsu_pkg.sv
design/lane_mem_if.sv
design/lsu_dispatch.sv
design/lsu_lane.sv
design/lsu_arbiter.sv
design/lsu_top.sv
test/tb_mem_model.sv
test/tb_lsu.sv

// File: test/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

    localparam int NUM_LANES = 4;
    localparam int NUM_OPS   = 75; // Directed 11, stall 4, random 60.
    localparam lsu_pkg::addr_t BASE = 64'h0000_0000_8000_0000;

    logic              clk = 1'b0;
    logic              rst;
    logic              op_valid;
    lsu_pkg::tag_t     op_tag;
    lsu_pkg::ld_type_t op_ld_type;
    lsu_pkg::st_type_t op_st_type;
    lsu_pkg::addr_t    op_addr;
    lsu_pkg::xlen_t    op_wdata;
    logic              op_ready;
    logic              mem_valid;
    logic              mem_write;
    logic              mem_ready;
    lsu_pkg::addr_t    mem_addr;
    lsu_pkg::size_t    mem_size;
    lsu_pkg::xlen_t    mem_wdata;
    lsu_pkg::xlen_t    mem_rdata;
    logic              res_valid;
    logic              res_is_load;
    lsu_pkg::tag_t     res_tag;
    lsu_pkg::xlen_t    res_rdata;
    logic [1:0]        ready_mode;

    logic [7:0]        shadow [256];
    logic [15:0]       pending;
    logic              exp_load [16];
    lsu_pkg::xlen_t    exp_rdata [16];
    lsu_pkg::addr_t    exp_addr [16];
    lsu_pkg::size_t    exp_size [16];
    lsu_pkg::xlen_t    exp_wdata [16];
    logic              serial_on;
    lsu_pkg::tag_t     serial_tag;
    logic [15:0]       lfsr_q;
    int                errors;
    int                issued;
    int                completed;

    always #10 clk = ~clk;

    lsu_top #(.NUM_LANES(NUM_LANES)) lsu_top_i (
        .clk             (clk),
        .rst             (rst),
        .op_valid_i      (op_valid),
        .op_tag_i        (op_tag),
        .op_ld_type_i    (op_ld_type),
        .op_st_type_i    (op_st_type),
        .op_addr_i       (op_addr),
        .op_wdata_i      (op_wdata),
        .op_ready_o      (op_ready),
        .mem_valid_o     (mem_valid),
        .mem_req_write_o (mem_write),
        .mem_addr_o      (mem_addr),
        .mem_size_o      (mem_size),
        .mem_wdata_o     (mem_wdata),
        .mem_ready_i     (mem_ready),
        .mem_rdata_i     (mem_rdata),
        .res_valid_o     (res_valid),
        .res_tag_o       (res_tag),
        .res_is_load_o   (res_is_load),
        .res_rdata_o     (res_rdata)
    );

    tb_mem_model mem_model_i (
        .clk          (clk),
        .ready_mode_i (ready_mode),
        .mem_valid_i  (mem_valid),
        .mem_write_i  (mem_write),
        .mem_addr_i   (mem_addr),
        .mem_size_i   (mem_size),
        .mem_wdata_i  (mem_wdata),
        .mem_ready_o  (mem_ready),
        .mem_rdata_o  (mem_rdata)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic lsu_pkg::size_t ld_size(input lsu_pkg::ld_type_t ld);
        case (ld)
            lsu_pkg::LB, lsu_pkg::LBU: return lsu_pkg::SIZE_B;
            lsu_pkg::LH, lsu_pkg::LHU: return lsu_pkg::SIZE_H;
            lsu_pkg::LW, lsu_pkg::LWU: return lsu_pkg::SIZE_W;
            default:                   return lsu_pkg::SIZE_D;
        endcase
    endfunction

    function automatic lsu_pkg::size_t st_size(input lsu_pkg::st_type_t st);
        case (st)
            lsu_pkg::SB: return lsu_pkg::SIZE_B;
            lsu_pkg::SH: return lsu_pkg::SIZE_H;
            lsu_pkg::SW: return lsu_pkg::SIZE_W;
            default:     return lsu_pkg::SIZE_D;
        endcase
    endfunction

    // Expected load value from the shadow memory.
    function automatic lsu_pkg::xlen_t ref_load(input lsu_pkg::addr_t addr,
                                                input lsu_pkg::ld_type_t ld);
        lsu_pkg::xlen_t val;
        int             nbytes;
        val    = '0;
        nbytes = 1 << ld_size(ld);
        for (int j = 0; j < nbytes; j++) begin
            val[8*j +: 8] = shadow[8'(addr[7:0] + 8'(j))];
        end
        if (!ld[2] && val[8*nbytes-1]) begin // Upper bit clear means signed.
            for (int b = 8 * nbytes; b < 64; b++) begin
                val[b] = 1'b1;
            end
        end
        return val;
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic check_rdata(input lsu_pkg::xlen_t got, input lsu_pkg::xlen_t exp);
        if (got !== exp)
            note_error($sformatf("res_rdata_o %h, expected %h", got, exp));
    endtask

    task automatic check_wdata(input lsu_pkg::xlen_t got, input lsu_pkg::xlen_t exp);
        if (got !== exp)
            note_error($sformatf("mem_wdata_o %h, expected %h", got, exp));
    endtask

    task automatic check_addr(input lsu_pkg::addr_t got, input lsu_pkg::addr_t exp);
        if (got !== exp)
            note_error($sformatf("mem_addr_o %h, expected %h", got, exp));
    endtask

    task automatic check_size(input lsu_pkg::size_t got, input lsu_pkg::size_t exp);
        if (got !== exp)
            note_error($sformatf("mem_size_o %0d, expected %0d", got, exp));
    endtask

    task automatic check_tag(input lsu_pkg::tag_t got, input lsu_pkg::tag_t exp);
        if (got !== exp)
            note_error($sformatf("res_tag_o %0d, expected %0d", got, exp));
    endtask

    task automatic check_kind(input logic got, input logic exp);
        if (got !== exp)
            note_error($sformatf("res_is_load_o %b, expected %b", got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            note_error($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic wait_tag(input lsu_pkg::tag_t tag);
        while (pending[tag]) begin
            @(negedge clk);
        end
    endtask

    // Tag picks the doubleword, so ops with different tags never overlap.
    task automatic issue_op(input lsu_pkg::tag_t tag, input lsu_pkg::ld_type_t ld,
                            input lsu_pkg::st_type_t st, input logic hi,
                            input logic [2:0] off, input lsu_pkg::xlen_t wdata);
        lsu_pkg::addr_t addr;
        lsu_pkg::xlen_t placed;
        addr = BASE | lsu_pkg::addr_t'({hi, tag, off});
        wait_tag(tag);
        op_valid   = 1'b1;
        op_tag     = tag;
        op_ld_type = ld;
        op_st_type = st;
        op_addr    = addr;
        op_wdata   = wdata;
        @(posedge clk);
        while (!op_ready) begin
            @(posedge clk);
        end
        pending[tag]  = 1'b1;
        exp_load[tag] = (ld != lsu_pkg::LD_NONE);
        exp_addr[tag] = addr;
        issued++;
        if (st != lsu_pkg::ST_NONE) begin
            exp_size[tag] = st_size(st);
            placed        = '0;
            for (int j = 0; j < 8 - int'(off); j++) begin
                placed[8*(int'(off) + j) +: 8] = wdata[8*j +: 8]; // Byte j to lane off+j.
            end
            exp_wdata[tag] = placed;
            for (int j = 0; j < (1 << st_size(st)); j++) begin
                shadow[8'(addr[7:0] + 8'(j))] = wdata[8*j +: 8];
            end
        end else begin
            exp_size[tag]  = ld_size(ld);
            exp_rdata[tag] = ref_load(addr, ld);
        end
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic run_serial(input lsu_pkg::tag_t tag, input lsu_pkg::ld_type_t ld,
                              input lsu_pkg::st_type_t st, input logic [2:0] off,
                              input lsu_pkg::xlen_t wdata);
        serial_tag = tag;
        issue_op(tag, ld, st, 1'b0, off, wdata);
        wait_tag(tag);
    endtask

    task automatic drain_all();
        int waited;
        waited = 0;
        while (pending != '0 && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        for (int t = 0; t < 16; t++) begin
            if (pending[t]) begin
                errors++;
                $display("Tag %0d was accepted but never completed", t);
                pending[t] = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && mem_valid && mem_ready) begin
            check_addr(mem_addr, exp_addr[mem_addr[6:3]]);
            check_size(mem_size, exp_size[mem_addr[6:3]]);
            check_flag("mem_req_write_o", mem_write, !exp_load[mem_addr[6:3]]);
            if (mem_write) begin
                check_wdata(mem_wdata, exp_wdata[mem_addr[6:3]]);
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && res_valid) begin
            completed++;
            if (serial_on) begin
                check_tag(res_tag, serial_tag);
            end
            if (!pending[res_tag]) begin
                errors++;
                $display("Tag %0d completed again or without an accepted operation", res_tag);
            end else begin
                pending[res_tag] = 1'b0;
                check_kind(res_is_load, exp_load[res_tag]);
                if (exp_load[res_tag]) begin
                    check_rdata(res_rdata, exp_rdata[res_tag]);
                end
            end
        end
    end

    initial begin
        repeat (NUM_OPS * 40 + 400) @(posedge clk);
        $display("Watchdog expired, the operations stopped making progress");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [63:0]       bits;
        lsu_pkg::ld_type_t ld;
        lsu_pkg::st_type_t st;
        lsu_pkg::size_t    sz;
        logic [2:0]        off;
        lsu_pkg::xlen_t    wdata;
        rst        = 1'b1;
        op_valid   = 1'b0;
        op_tag     = '0;
        op_ld_type = lsu_pkg::LD_NONE;
        op_st_type = lsu_pkg::ST_NONE;
        op_addr    = '0;
        op_wdata   = '0;
        ready_mode = 2'd0;
        pending    = '0;
        serial_on  = 1'b0;
        serial_tag = '0;
        lfsr_q     = 16'd8701;
        errors     = 0;
        issued     = 0;
        completed  = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int a = 0; a < 256; a++) begin
            shadow[a] = mem_model_i.mem[a];
        end
        check_flag("op_ready_o after reset", op_ready, 1'b1);
        check_flag("mem_valid_o after reset", mem_valid, 1'b0);
        check_flag("res_valid_o after reset", res_valid, 1'b0);

        serial_on = 1'b1; // One op at a time with negative values for sign checks.
        run_serial(4'd0, lsu_pkg::LD_NONE, lsu_pkg::SD, 3'd0, 64'hfedc_ba98_8765_4321);
        run_serial(4'd1, lsu_pkg::LD_NONE, lsu_pkg::SW, 3'd4, 64'h0000_0000_8000_1234);
        run_serial(4'd2, lsu_pkg::LD_NONE, lsu_pkg::SH, 3'd2, 64'h0000_0000_0000_9abc);
        run_serial(4'd3, lsu_pkg::LD_NONE, lsu_pkg::SB, 3'd7, 64'h0000_0000_0000_0085);
        run_serial(4'd3, lsu_pkg::LB, lsu_pkg::ST_NONE, 3'd7, '0);
        run_serial(4'd3, lsu_pkg::LBU, lsu_pkg::ST_NONE, 3'd7, '0);
        run_serial(4'd2, lsu_pkg::LH, lsu_pkg::ST_NONE, 3'd2, '0);
        run_serial(4'd2, lsu_pkg::LHU, lsu_pkg::ST_NONE, 3'd2, '0);
        run_serial(4'd1, lsu_pkg::LW, lsu_pkg::ST_NONE, 3'd4, '0);
        run_serial(4'd1, lsu_pkg::LWU, lsu_pkg::ST_NONE, 3'd4, '0);
        run_serial(4'd0, lsu_pkg::LD, lsu_pkg::ST_NONE, 3'd0, '0);
        serial_on = 1'b0;

        ready_mode = 2'd2; // Memory stalled with one op per lane.
        issue_op(4'd4, lsu_pkg::LD_NONE, lsu_pkg::SW, 1'b1, 3'd0, 64'h1111_2222_3333_4444);
        issue_op(4'd5, lsu_pkg::LB, lsu_pkg::ST_NONE, 1'b1, 3'd3, '0);
        issue_op(4'd6, lsu_pkg::LD_NONE, lsu_pkg::SD, 1'b1, 3'd0, 64'h0123_4567_89ab_cdef);
        issue_op(4'd7, lsu_pkg::LHU, lsu_pkg::ST_NONE, 1'b1, 3'd6, '0);
        check_flag("op_ready_o with all lanes busy", op_ready, 1'b0);
        repeat (5) @(negedge clk);
        check_flag("op_ready_o during memory stall", op_ready, 1'b0);
        ready_mode = 2'd0;
        drain_all();

        ready_mode = 2'd1;
        for (int i = 0; i < 60; i++) begin
            bits = take_bits(1);
            if (bits[0]) begin
                bits = take_bits(2);
                st   = lsu_pkg::st_type_t'({1'b1, bits[1:0]});
                ld   = lsu_pkg::LD_NONE;
                sz   = st_size(st);
            end else begin
                bits = take_bits(3);
                ld   = lsu_pkg::ld_type_t'(bits[2:0]);
                if (ld == lsu_pkg::LD_NONE) begin
                    ld = lsu_pkg::LD;
                end
                st = lsu_pkg::ST_NONE;
                sz = ld_size(ld);
            end
            bits  = take_bits(3);
            off   = bits[2:0] & ~3'((1 << sz) - 1); // Natural alignment.
            wdata = take_bits(64);
            bits  = take_bits(1);
            issue_op(4'(i), ld, st, bits[0], off, wdata);
        end
        drain_all();

        $display("Run summary: %0d ops issued, %0d results, %0d errors",
                 issued, completed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: test/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic           clk,
    input  logic [1:0]     ready_mode_i,
    input  logic           mem_valid_i,
    input  logic           mem_write_i,
    input  lsu_pkg::addr_t mem_addr_i,
    input  lsu_pkg::size_t mem_size_i,
    input  lsu_pkg::xlen_t mem_wdata_i,
    output logic           mem_ready_o,
    output lsu_pkg::xlen_t mem_rdata_o
);

    logic [7:0]  mem [256];
    logic [15:0] lfsr_q;
    logic [1:0]  draw;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        logic [7:0] byte_v;
        lfsr_q      = 16'd8701;
        mem_ready_o <= 1'b0;
        for (int a = 0; a < 256; a++) begin
            for (int b = 0; b < 8; b++) begin
                lfsr_q    = lfsr_next(lfsr_q);
                byte_v[b] = lfsr_q[0];
            end
            mem[a] <= byte_v;
        end
    end

    // Mode 0 always ready, mode 1 ready three times in four, mode 2 stalled.
    always @(negedge clk) begin
        if (ready_mode_i == 2'd1) begin
            for (int b = 0; b < 2; b++) begin
                lfsr_q  = lfsr_next(lfsr_q);
                draw[b] = lfsr_q[0];
            end
            mem_ready_o <= |draw;
        end else begin
            mem_ready_o <= (ready_mode_i == 2'd0);
        end
    end

    always_comb begin
        for (int j = 0; j < 8; j++) begin
            mem_rdata_o[8*j +: 8] = mem[{mem_addr_i[7:3], 3'(j)}]; // Whole doubleword.
        end
    end

    always @(posedge clk) begin
        if (mem_valid_i && mem_ready_o && mem_write_i) begin
            for (int j = 0; j < 8; j++) begin
                if (j < (1 << mem_size_i)) begin
                    mem[8'(mem_addr_i[7:0] + 8'(j))] <=
                        mem_wdata_i[8*(int'(mem_addr_i[2:0]) + j) +: 8]; // Byte lanes.
                end
            end
        end
    end

endmodule

// File: design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid_i,
    input  lsu_pkg::tag_t       op_tag_i,
    input  lsu_pkg::ld_type_t   op_ld_type_i,
    input  lsu_pkg::st_type_t   op_st_type_i,
    input  lsu_pkg::addr_t      op_addr_i,
    input  lsu_pkg::xlen_t      op_wdata_i,
    output logic                op_ready_o,
    output logic                mem_valid_o,
    output logic                mem_req_write_o,
    output lsu_pkg::addr_t      mem_addr_o,
    output lsu_pkg::size_t      mem_size_o,
    output lsu_pkg::xlen_t      mem_wdata_o,
    input  logic                mem_ready_i,
    input  lsu_pkg::xlen_t      mem_rdata_i,
    output logic                res_valid_o,
    output lsu_pkg::tag_t       res_tag_o,
    output logic                res_is_load_o,
    output lsu_pkg::xlen_t      res_rdata_o
);

    lsu_pkg::mem_op_t     op_in;
    lsu_pkg::mem_op_t     lane_op;
    lsu_pkg::mem_res_t    res;
    logic [NUM_LANES-1:0] lane_start;
    logic [NUM_LANES-1:0] credit_return;

    assign op_in = '{tag: op_tag_i, ld_type: op_ld_type_i, st_type: op_st_type_i,
                     addr: op_addr_i, wdata: op_wdata_i};

    lsu_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
        .clk             (clk),
        .rst             (rst),
        .op_valid_i      (op_valid_i),
        .op_i            (op_in),
        .op_ready_o      (op_ready_o),
        .credit_return_i (credit_return),
        .lane_start_o    (lane_start),
        .lane_op_o       (lane_op)
    );

    lane_mem_if lane_bus [NUM_LANES] ();

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lanes
        lsu_lane u_lane (
            .clk     (clk),
            .rst     (rst),
            .start_i (lane_start[k]),
            .op_i    (lane_op),
            .bus     (lane_bus[k])
        );
    end

    lsu_arbiter #(.NUM_LANES(NUM_LANES)) u_arbiter (
        .clk             (clk),
        .rst             (rst),
        .lanes           (lane_bus),
        .mem_valid_o     (mem_valid_o),
        .mem_req_write_o (mem_req_write_o),
        .mem_addr_o      (mem_addr_o),
        .mem_size_o      (mem_size_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_ready_i     (mem_ready_i),
        .mem_rdata_i     (mem_rdata_i),
        .res_valid_o     (res_valid_o),
        .res_o           (res),
        .credit_return_o (credit_return)
    );

    assign res_tag_o     = res.tag;
    assign res_is_load_o = res.is_load;
    assign res_rdata_o   = res.rdata;

endmodule

// File: design/lsu_arbiter.sv
`timescale 1ns/1ps

module lsu_arbiter #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    lane_mem_if.arbiter          lanes [NUM_LANES],
    output logic                 mem_valid_o,
    output logic                 mem_req_write_o,
    output lsu_pkg::addr_t       mem_addr_o,
    output lsu_pkg::size_t       mem_size_o,
    output lsu_pkg::xlen_t       mem_wdata_o,
    input  logic                 mem_ready_i,
    input  lsu_pkg::xlen_t       mem_rdata_i,
    output logic                 res_valid_o,
    output lsu_pkg::mem_res_t    res_o,
    output logic [NUM_LANES-1:0] credit_return_o
);

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0] req_valid;
    logic [NUM_LANES-1:0] req_write;
    lsu_pkg::addr_t       req_addr [NUM_LANES];
    lsu_pkg::size_t       req_size [NUM_LANES];
    lsu_pkg::xlen_t       req_wdata [NUM_LANES];
    logic [NUM_LANES-1:0] done;
    lsu_pkg::mem_res_t    res [NUM_LANES];
    logic [NUM_LANES-1:0] grant_vec;
    logic [NUM_LANES-1:0] drain_vec;

    logic [IDX_W-1:0] mem_ptr_q, owner_q, mem_sel;
    logic             locked_q;
    logic [IDX_W-1:0] drain_ptr_q, drain_sel;
    logic             handshake;
    lsu_pkg::mem_res_t res_q;
    logic             res_valid_q;

    function automatic logic [IDX_W-1:0] rr_pick(input logic [NUM_LANES-1:0] req,
                                                  input logic [IDX_W-1:0] ptr);
        logic [IDX_W-1:0] pick;
        logic             found;
        int               idx;
        pick  = ptr;
        found = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = int'(ptr) + i;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (req[idx] && !found) begin
                pick  = IDX_W'(idx);
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        return (int'(idx) == NUM_LANES - 1) ? '0 : idx + 1'b1;
    endfunction

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign req_valid[i]    = lanes[i].req_valid;
        assign req_write[i]    = lanes[i].req_write;
        assign req_addr[i]     = lanes[i].req_addr;
        assign req_size[i]     = lanes[i].req_size;
        assign req_wdata[i]    = lanes[i].req_wdata;
        assign done[i]         = lanes[i].done;
        assign res[i]          = lanes[i].res;
        assign grant_vec[i]    = handshake && (int'(mem_sel) == i);
        assign drain_vec[i]    = (|done) && (int'(drain_sel) == i);
        assign lanes[i].grant  = grant_vec[i];
        assign lanes[i].rdata  = mem_rdata_i;
        assign lanes[i].drain  = drain_vec[i];
    end

    // Stalled owner keeps the port until its handshake.
    assign mem_sel         = locked_q ? owner_q : rr_pick(req_valid, mem_ptr_q);
    assign mem_valid_o     = req_valid[mem_sel];
    assign mem_req_write_o = req_write[mem_sel];
    assign mem_addr_o      = req_addr[mem_sel];
    assign mem_size_o      = req_size[mem_sel];
    assign mem_wdata_o     = req_wdata[mem_sel];
    assign handshake       = mem_valid_o && mem_ready_i;

    assign drain_sel       = rr_pick(done, drain_ptr_q);
    assign credit_return_o = drain_vec;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ptr_q   <= '0;
            owner_q     <= '0;
            locked_q    <= 1'b0;
            drain_ptr_q <= '0;
            res_valid_q <= 1'b0;
        end else begin
            if (handshake) begin
                locked_q  <= 1'b0;
                mem_ptr_q <= next_idx(mem_sel);
            end else if (mem_valid_o) begin
                locked_q <= 1'b1;
                owner_q  <= mem_sel;
            end
            if (|done) begin
                drain_ptr_q <= next_idx(drain_sel);
            end
            res_valid_q <= |done;
        end
    end

    always_ff @(posedge clk) begin
        if (|done) begin
            res_q <= res[drain_sel];
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

    // Granted lane is still waiting on memory, never one holding a result.
    assert property (@(posedge clk) disable iff (rst)
        (grant_vec & done) == '0);

    // Request must hold still through a stall.
    assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o)
                                        && $stable(mem_wdata_o));

endmodule

// File: design/lsu_lane.sv
`timescale 1ns/1ps

module lsu_lane (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_i,
    input  lsu_pkg::mem_op_t op_i,
    lane_mem_if.lane         bus
);

    lsu_pkg::mem_op_t op_q;
    logic             busy_q;
    logic             finished_q;
    lsu_pkg::xlen_t   rdata_q;
    lsu_pkg::size_t   size;
    logic [2:0]       align_mask;
    logic             is_store;
    logic             is_load;
    lsu_pkg::xlen_t   shifted;
    lsu_pkg::xlen_t   load_ext;

    assign is_store = op_q.st_type[2];
    assign is_load  = (op_q.ld_type != lsu_pkg::LD_NONE);

    always_comb begin
        if (is_store) begin
            size = lsu_pkg::size_t'(op_q.st_type[1:0]); // Store code is the size.
        end else begin
            case (op_q.ld_type)
                lsu_pkg::LB, lsu_pkg::LBU: size = lsu_pkg::SIZE_B;
                lsu_pkg::LH, lsu_pkg::LHU: size = lsu_pkg::SIZE_H;
                lsu_pkg::LW, lsu_pkg::LWU: size = lsu_pkg::SIZE_W;
                default:                   size = lsu_pkg::SIZE_D;
            endcase
        end
        case (size)
            lsu_pkg::SIZE_B: align_mask = 3'b000;
            lsu_pkg::SIZE_H: align_mask = 3'b001;
            lsu_pkg::SIZE_W: align_mask = 3'b011;
            default:         align_mask = 3'b111;
        endcase
    end

    // Memory returns the whole doubleword; move the addressed bytes down first.
    assign shifted = bus.rdata >> {op_q.addr[2:0], 3'b000};

    always_comb begin
        case (op_q.ld_type)
            lsu_pkg::LB:  load_ext = {{56{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LH:  load_ext = {{48{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LW:  load_ext = {{32{shifted[31]}}, shifted[31:0]};
            lsu_pkg::LBU: load_ext = {56'd0, shifted[7:0]};
            lsu_pkg::LHU: load_ext = {48'd0, shifted[15:0]};
            lsu_pkg::LWU: load_ext = {32'd0, shifted[31:0]};
            lsu_pkg::LD:  load_ext = shifted;
            default:      load_ext = '0; // Stores report zero.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= 1'b0;
            finished_q <= 1'b0;
        end else begin
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (bus.drain) begin
                busy_q <= 1'b0;
            end
            if (start_i) begin
                finished_q <= 1'b0;
            end else if (bus.grant) begin
                finished_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            op_q <= op_i;
        end
        if (bus.grant) begin
            rdata_q <= load_ext;
        end
    end

    assign bus.req_valid   = busy_q && !finished_q;
    assign bus.req_write   = is_store;
    assign bus.req_addr    = op_q.addr;
    assign bus.req_size    = size;
    assign bus.req_wdata   = op_q.wdata << {op_q.addr[2:0], 3'b000};
    assign bus.done        = busy_q && finished_q;
    assign bus.res.tag     = op_q.tag;
    assign bus.res.is_load = is_load;
    assign bus.res.rdata   = rdata_q;

    // Credit flow must keep a held op from being overwritten.
    assert property (@(posedge clk) disable iff (rst) start_i |-> !busy_q);

    assert property (@(posedge clk) disable iff (rst)
        bus.req_valid |-> (op_q.addr[2:0] & align_mask) == 3'b000);

endmodule

// File: design/lsu_dispatch.sv
`timescale 1ns/1ps

module lsu_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_valid_i,
    input  lsu_pkg::mem_op_t        op_i,
    output logic                    op_ready_o,
    input  logic [NUM_LANES-1:0]    credit_return_i,
    output logic [NUM_LANES-1:0]    lane_start_o,
    output lsu_pkg::mem_op_t        lane_op_o
);

    localparam int CNT_W = $clog2(lsu_pkg::LANE_CREDITS + 1);

    logic [CNT_W-1:0]     credit_q [NUM_LANES];
    logic [NUM_LANES-1:0] has_credit;
    logic [NUM_LANES-1:0] spend;
    logic [NUM_LANES-1:0] lane_start_q;
    lsu_pkg::mem_op_t     lane_op_q;

    always_comb begin
        logic found;
        found = 1'b0;
        spend = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            has_credit[i] = (credit_q[i] != '0);
            if (has_credit[i] && !found) begin // Lowest lane wins.
                spend[i] = op_valid_i;
                found    = 1'b1;
            end
        end
    end

    assign op_ready_o = |has_credit;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                credit_q[i] <= CNT_W'(lsu_pkg::LANE_CREDITS);
            end
            lane_start_q <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                credit_q[i] <= credit_q[i] + CNT_W'(credit_return_i[i]) - CNT_W'(spend[i]);
            end
            lane_start_q <= spend;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid_i && op_ready_o) begin
            lane_op_q <= op_i; // Shared op bus, one start bit picks the lane.
        end
    end

    assign lane_start_o = lane_start_q;
    assign lane_op_o    = lane_op_q;

    // A lane that still holds its credit must not see one come back.
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_credit_chk
        assert property (@(posedge clk) disable iff (rst)
            credit_return_i[i] |-> credit_q[i] != CNT_W'(lsu_pkg::LANE_CREDITS));
    end

endmodule

// File: design/lane_mem_if.sv
`timescale 1ns/1ps

interface lane_mem_if;

    logic             req_valid;
    logic             req_write;
    lsu_pkg::addr_t   req_addr;
    lsu_pkg::size_t   req_size;
    lsu_pkg::xlen_t   req_wdata;
    logic             done;      // Result waiting for drain.
    lsu_pkg::mem_res_t res;

    logic             grant;     // Memory handshake for this lane.
    lsu_pkg::xlen_t   rdata;
    logic             drain;

    modport lane (
        output req_valid, req_write, req_addr, req_size, req_wdata,
        output done, res,
        input  grant, rdata, drain
    );

    modport arbiter (
        input  req_valid, req_write, req_addr, req_size, req_wdata,
        input  done, res,
        output grant, rdata, drain
    );

endinterface

// File: design/lsu_pkg.sv
package lsu_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [63:0] addr_t;
    typedef logic [3:0]  tag_t;

    // Upper bit set means zero-extend. LD sits alone at 3'b100.
    typedef enum logic [2:0] {
        LD_NONE = 3'b000,
        LB      = 3'b001,
        LH      = 3'b010,
        LW      = 3'b011,
        LD      = 3'b100,
        LBU     = 3'b101,
        LHU     = 3'b110,
        LWU     = 3'b111
    } ld_type_t;

    // Upper bit set means a store is present, low bits are the size code.
    typedef enum logic [2:0] {
        ST_NONE = 3'b000,
        SB      = 3'b100,
        SH      = 3'b101,
        SW      = 3'b110,
        SD      = 3'b111
    } st_type_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10,
        SIZE_D = 2'b11
    } size_t;

    parameter int unsigned LANE_CREDITS = 1; // Ops a lane can hold.

    typedef struct packed {
        tag_t     tag;
        ld_type_t ld_type;
        st_type_t st_type;
        addr_t    addr;
        xlen_t    wdata;
    } mem_op_t;

    typedef struct packed {
        tag_t  tag;
        logic  is_load;
        xlen_t rdata;
    } mem_res_t;

endpackage
